// ==== hw/snoop_arb_consts.svh ====
// sizing constants for the snoop request arbiter, included by the package and the rtl
`ifndef SNOOP_ARB_CONSTS_SVH
`define SNOOP_ARB_CONSTS_SVH

// ============================================================
// address and payload widths
// ============================================================

// physical address width of the ac channel
`define SNP_PA_WIDTH 40

// dependency vector widths, wmb above vb in the snq entry
`define SNP_WMB_DEPD_W 8
`define SNP_VB_DEPD_W 2

// ============================================================
// queue depths
// ============================================================

// snoop queue and cache/tlb maintenance queue
`define SNP_SNQ_ENTRIES 6
`define SNP_CTCQ_ENTRIES 6

// create order queue, must cover snq plus two ctcq transactions each
`define SNP_COQ_ENTRIES 18
`define SNP_COQ_PTR_W 5

// ac snoop code of a ctc request
`define SNP_CTC_CODE 4'b1111

`endif

// ==== hw/snoop_arb_pkg.sv ====
// packed struct types shared by the snoop arbiter rtl and its testbench
`include "snoop_arb_consts.svh"

package snoop_arb_pkg;

  // ============================================================
  // ac channel side
  // ============================================================

  // ac payload, held by the bus until ready
  typedef struct packed {
    logic [`SNP_PA_WIDTH-1:0] addr;
    logic [2:0]               prot;
    logic [3:0]               snoop;
  } ac_req_t;

  // admission conditions from the queues and the coherence unit
  typedef struct packed {
    logic snq_entry_empty;
    logic ctcq_entry_empty;
    logic create_permit;
    logic lm_stall;
  } snp_permit_t;

  // ============================================================
  // queue entry contents
  // ============================================================

  // snq entry, depd is wmb bits above vb bits
  typedef struct packed {
    logic [`SNP_WMB_DEPD_W+`SNP_VB_DEPD_W-1:0] depd;
    logic [3:0]                                 snoop_type;
    logic [`SNP_PA_WIDTH-1:0]                   addr;
    logic [2:0]                                 prot;
  } snq_entry_t;

  // ctcq entry, decoded from the first transaction address
  typedef struct packed {
    logic [5:0]                ctc_type;
    logic [`SNP_PA_WIDTH-17:0] asid_va;
    logic                      second_trans;
    logic [`SNP_PA_WIDTH-5:0]  va_pa;
  } ctcq_entry_t;

  // ============================================================
  // response side and activity
  // ============================================================

  // cr status, one order entry popped per accept
  typedef struct packed {
    logic snq_cr_valid;
    logic ctcq_cr_valid;
    logic ctcq_2_cmplt;
    logic resp_accept;
  } cr_stat_t;

  // activity flags feeding the ac empty indication
  typedef struct packed {
    logic snq_not_empty;
    logic sdb_not_empty;
    logic ctcq_not_empty;
  } snp_busy_t;

endpackage

// ==== hw/snoop_admit.sv ====
// admission logic for ac snoop requests: ready, create enables and queue entry fields
`include "snoop_arb_consts.svh"

module snoop_admit (
  input  logic                        ac_req,
  input  snoop_arb_pkg::ac_req_t      ac,
  input  snoop_arb_pkg::snp_permit_t  permit,
  input  logic [`SNP_WMB_DEPD_W-1:0]  wmb_depd,
  input  logic [`SNP_VB_DEPD_W-1:0]   vb_depd,
  input  snoop_arb_pkg::snp_busy_t    busy,
  output logic                        ac_ready,
  output logic                        snoop_create_en,
  output logic                        ctc_create_en,
  output logic                        ac_empty,
  output snoop_arb_pkg::snq_entry_t   snq_entry,
  output snoop_arb_pkg::ctcq_entry_t  ctcq_entry
);

  logic ctc_req;
  logic snp_req;
  logic snoop_aft_check;
  logic ctc_aft_check;
  logic snoop_active;

  // ============================================================
  // request classification
  // ============================================================

  // all four snoop bits set marks cache/tlb maintenance
  assign ctc_req = ac_req && (ac.snoop == `SNP_CTC_CODE);
  // anything else is a normal snoop
  assign snp_req = ac_req && !ctc_req;

  // ============================================================
  // ready and create enables
  // ============================================================

  // snq needs coherence unit idle, no load miss stall, free entry
  assign snoop_aft_check = snp_req
                        && permit.create_permit
                        && !permit.lm_stall
                        && permit.snq_entry_empty;

  // ctcq only needs its current entry free
  assign ctc_aft_check = ctc_req && permit.ctcq_entry_empty;

  // target queue must be free, stall and permit gate both kinds
  assign ac_ready = ((permit.snq_entry_empty && snp_req)
                  || (permit.ctcq_entry_empty && ctc_req))
                 && !permit.lm_stall
                 && permit.create_permit;

  // at most one of these per handshake
  assign snoop_create_en = snoop_aft_check && ac_ready;
  assign ctc_create_en   = ctc_aft_check && ac_ready;

  // ============================================================
  // idle indication
  // ============================================================

  // any pending request or queued work keeps the snoop path busy
  assign snoop_active = ac_req
                     || busy.snq_not_empty
                     || busy.sdb_not_empty
                     || busy.ctcq_not_empty;

  // used by the core to decide idle
  assign ac_empty = !snoop_active;

  // ============================================================
  // snq entry contents
  // ============================================================

  // depd from wmb/vb address match, only meaningful for snoops
  assign snq_entry = '{
    depd:       {wmb_depd, vb_depd},
    snoop_type: ac.snoop,
    addr:       ac.addr,
    prot:       ac.prot
  };

  // ============================================================
  // ctcq entry contents
  // ============================================================

  // type from addr[14:12], addr[6:5], addr[0]
  //   000 00 0 tlbi all, 000 00 1 tlbi va all
  //   000 01 0 tlbi asid all, 000 01 1 tlbi va asid
  //   010 00 0 ici all, 010 11 1 ici va
  // asid or va from upper address bits of the first transaction
  // va/pa field is taken when the second transaction arrives
  assign ctcq_entry = '{
    ctc_type:     {ac.addr[14:12], ac.addr[6:5], ac.addr[0]},
    asid_va:      ac.addr[`SNP_PA_WIDTH-1:16],
    second_trans: ac.addr[0],
    va_pa:        ac.addr[`SNP_PA_WIDTH-1:4]
  };

endmodule

// ==== hw/snoop_order_tracker.sv ====
// create order queue for snq and ctcq entries, selects the queue holding the oldest entry
`include "snoop_arb_consts.svh"

module snoop_order_tracker (
  input  logic                    snpcrtclk,
  input  logic                    cpurst_b,
  input  logic                    snoop_create_en,
  input  logic                    ctc_create_en,
  input  snoop_arb_pkg::cr_stat_t cr,
  output logic                    oldest_is_ctcq,
  output logic                    snq_advance,
  output logic                    ctcq_advance
);

  // last slot index, pointers wrap here
  localparam logic [`SNP_COQ_PTR_W-1:0] COQ_LAST = `SNP_COQ_ENTRIES - 1;
  localparam logic [`SNP_COQ_PTR_W-1:0] PTR_ONE  = 1;

  logic [`SNP_COQ_PTR_W-1:0]  coq_create_ptr;
  logic [`SNP_COQ_PTR_W-1:0]  coq_pop_ptr;
  // one bit per slot, 0 snq, 1 ctcq
  logic [`SNP_COQ_ENTRIES-1:0] create_order_source;
  logic                        coq_create_en;

  // ============================================================
  // create side
  // ============================================================

  assign coq_create_en = snoop_create_en || ctc_create_en;

  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      coq_create_ptr <= '0;
    else if (coq_create_en)
    begin
      // slots 0..17
      if (coq_create_ptr == COQ_LAST)
        coq_create_ptr <= '0;
      else
        coq_create_ptr <= coq_create_ptr + PTR_ONE;
    end
  end

  // source kind recorded at the create pointer
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      create_order_source <= '0;
    else if (coq_create_en)
      create_order_source[coq_create_ptr] <= ctc_create_en;
  end

  // ============================================================
  // pop side
  // ============================================================

  // each accepted cr response retires one order entry
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      coq_pop_ptr <= '0;
    else if (cr.resp_accept)
    begin
      if (coq_pop_ptr == COQ_LAST)
        coq_pop_ptr <= '0;
      else
        coq_pop_ptr <= coq_pop_ptr + PTR_ONE;
    end
  end

  // head of the order queue
  assign oldest_is_ctcq = create_order_source[coq_pop_ptr];

  // snq entry done on its cr
  assign snq_advance  = cr.resp_accept && cr.snq_cr_valid;
  // ctcq entry stays while the second transaction is pending
  assign ctcq_advance = cr.resp_accept && cr.ctcq_cr_valid && !cr.ctcq_2_cmplt;

endmodule

// ==== hw/oldest_index_ring.sv ====
// rotating one-hot oldest entry pointer of one queue, masked by the order selection
module oldest_index_ring #(
  parameter int ENTRIES = 6
) (
  input  logic               snpcrtclk,
  input  logic               cpurst_b,
  input  logic               advance,
  input  logic               select,
  output logic [ENTRIES-1:0] oldest_index
);

  // entry 0 is oldest out of reset
  localparam logic [ENTRIES-1:0] FIRST_ENTRY = ENTRIES'(1);

  logic [ENTRIES-1:0] oldest_ptr;

  // ============================================================
  // one-hot rotation
  // ============================================================

  // move toward higher entries, top wraps to bit 0
  always_ff @(posedge snpcrtclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      oldest_ptr <= FIRST_ENTRY;
    else if (advance)
      oldest_ptr <= {oldest_ptr[ENTRIES-2:0], oldest_ptr[ENTRIES-1]};
  end

  // ============================================================
  // masked output
  // ============================================================

  // only shown when this queue holds the globally oldest entry
  assign oldest_index = oldest_ptr & {ENTRIES{select}};

endmodule

// ==== hw/snoop_req_arbiter.sv ====
// top level of the lsu snoop request arbiter, admission plus create order tracking
`include "snoop_arb_consts.svh"

module snoop_req_arbiter (
  input  logic                         snpcrtclk,
  input  logic                         cpurst_b,
  // ac channel
  input  logic                         ac_req,
  input  snoop_arb_pkg::ac_req_t       ac,
  output logic                         ac_ready,
  // admission conditions and dependency info
  input  snoop_arb_pkg::snp_permit_t   permit,
  input  logic [`SNP_WMB_DEPD_W-1:0]   wmb_depd,
  input  logic [`SNP_VB_DEPD_W-1:0]    vb_depd,
  input  snoop_arb_pkg::snp_busy_t     busy,
  // cr response side
  input  snoop_arb_pkg::cr_stat_t      cr,
  // queue create interface
  output logic                         snoop_create_en,
  output logic                         ctc_create_en,
  output snoop_arb_pkg::snq_entry_t    snq_entry,
  output snoop_arb_pkg::ctcq_entry_t   ctcq_entry,
  // low power idle
  output logic                         ac_empty,
  // oldest entry per queue for response return
  output logic [`SNP_SNQ_ENTRIES-1:0]  snq_oldest_index,
  output logic [`SNP_CTCQ_ENTRIES-1:0] ctcq_oldest_index
);

  logic oldest_is_ctcq;
  logic snq_advance;
  logic ctcq_advance;

  // ============================================================
  // admission and entry build
  // ============================================================

  snoop_admit admit_inst (
    .ac_req          (ac_req),
    .ac              (ac),
    .permit          (permit),
    .wmb_depd        (wmb_depd),
    .vb_depd         (vb_depd),
    .busy            (busy),
    .ac_ready        (ac_ready),
    .snoop_create_en (snoop_create_en),
    .ctc_create_en   (ctc_create_en),
    .ac_empty        (ac_empty),
    .snq_entry       (snq_entry),
    .ctcq_entry      (ctcq_entry)
  );

  // ============================================================
  // create order and oldest pointers
  // ============================================================

  snoop_order_tracker order_inst (
    .snpcrtclk       (snpcrtclk),
    .cpurst_b        (cpurst_b),
    .snoop_create_en (snoop_create_en),
    .ctc_create_en   (ctc_create_en),
    .cr              (cr),
    .oldest_is_ctcq  (oldest_is_ctcq),
    .snq_advance     (snq_advance),
    .ctcq_advance    (ctcq_advance)
  );

  // snq shown when the head entry is not ctcq
  oldest_index_ring #(.ENTRIES(`SNP_SNQ_ENTRIES)) snq_ring (
    .snpcrtclk    (snpcrtclk),
    .cpurst_b     (cpurst_b),
    .advance      (snq_advance),
    .select       (!oldest_is_ctcq),
    .oldest_index (snq_oldest_index)
  );

  oldest_index_ring #(.ENTRIES(`SNP_CTCQ_ENTRIES)) ctcq_ring (
    .snpcrtclk    (snpcrtclk),
    .cpurst_b     (cpurst_b),
    .advance      (ctcq_advance),
    .select       (oldest_is_ctcq),
    .oldest_index (ctcq_oldest_index)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// clock and active low reset source for the snoop arbiter testbench
module tb_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic snpcrtclk,
  output logic cpurst_b
);
  timeunit 1ns;
  timeprecision 100ps;

  // free running, first rising edge at half a period
  initial
  begin
    snpcrtclk = 1'b0;
    forever #(PERIOD_NS / 2) snpcrtclk = ~snpcrtclk;
  end

  // released a quarter period after the fifth falling edge
  initial
  begin
    cpurst_b = 1'b0;
    #(PERIOD_NS * RESET_CYCLES + PERIOD_NS / 4);
    cpurst_b = 1'b1;
  end

endmodule

// ==== verif/snoop_req_arbiter_assert.sv ====
// concurrent checks on create enables and oldest indices, bound into the arbiter top level
`include "snoop_arb_consts.svh"

module snoop_arb_assert (
  input logic                         snpcrtclk,
  input logic                         cpurst_b,
  input logic                         ac_ready,
  input logic                         snoop_create_en,
  input logic                         ctc_create_en,
  input logic [`SNP_SNQ_ENTRIES-1:0]  snq_oldest_index,
  input logic [`SNP_CTCQ_ENTRIES-1:0] ctcq_oldest_index
);
  timeunit 1ns;
  timeprecision 100ps;

  // failures seen so far, read by the testbench at the end
  int assert_fail_count = 0;

  // ============================================================
  // create side
  // ============================================================

  // one queue per handshake
  create_exclusive: assert property (@(posedge snpcrtclk) disable iff (!cpurst_b)
    !(snoop_create_en && ctc_create_en))
  else
  begin
    assert_fail_count++;
    $error("snoop and ctc create enables high in the same cycle");
  end

  // no create without ready
  create_needs_ready: assert property (@(posedge snpcrtclk) disable iff (!cpurst_b)
    (snoop_create_en || ctc_create_en) |-> ac_ready)
  else
  begin
    assert_fail_count++;
    $error("create enable high while ac_ready low");
  end

  // ============================================================
  // oldest pointers
  // ============================================================

  oldest_onehot: assert property (@(posedge snpcrtclk) disable iff (!cpurst_b)
    $onehot0(snq_oldest_index) && $onehot0(ctcq_oldest_index))
  else
  begin
    assert_fail_count++;
    $error("oldest index with more than one bit set");
  end

endmodule

bind snoop_req_arbiter snoop_arb_assert assert_inst (.*);

// ==== verif/snoop_req_arbiter_tb.sv ====
// random stimulus testbench for the snoop request arbiter, checked against an order model
`include "snoop_arb_consts.svh"

module snoop_req_arbiter_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import snoop_arb_pkg::*;

  localparam int RAND_CYCLES = 400;
  localparam int DRAIN_LIMIT = 200;
  localparam int WAIT_LIMIT  = 100;
  localparam int RESET_LIMIT = 20;
  localparam int SETTLE_NS   = 10;
  localparam int NUM_TESTS   = 7;

  logic snpcrtclk;
  logic cpurst_b;
  logic ac_req;
  ac_req_t ac;
  snp_permit_t permit;
  logic [`SNP_WMB_DEPD_W-1:0] wmb_depd;
  logic [`SNP_VB_DEPD_W-1:0] vb_depd;
  snp_busy_t busy;
  cr_stat_t cr;
  logic ac_ready;
  logic snoop_create_en;
  logic ctc_create_en;
  logic ac_empty;
  snq_entry_t snq_entry;
  ctcq_entry_t ctcq_entry;
  logic [`SNP_SNQ_ENTRIES-1:0] snq_oldest_index;
  logic [`SNP_CTCQ_ENTRIES-1:0] ctcq_oldest_index;

  // ============================================================
  // model state
  // ============================================================

  // creation order, 1 marks a ctcq entry
  bit order_q [$];
  logic [`SNP_SNQ_ENTRIES-1:0] snq_ring_m;
  logic [`SNP_CTCQ_ENTRIES-1:0] ctcq_ring_m;
  bit pending;
  int req_wait;
  bit hs_now;
  bit hs_ctc;
  bit timed_out;
  int checks [NUM_TESTS];
  int errors [NUM_TESTS];
  string test_name [NUM_TESTS] = '{"reset_state", "admission", "snq_entry",
                                   "ctcq_decode", "order_mask", "ring_rotation",
                                   "empty_ind"};

  tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) clk_gen_inst (
    .snpcrtclk (snpcrtclk),
    .cpurst_b  (cpurst_b)
  );

  snoop_req_arbiter snoop_req_arbiter_inst (.*);

  task automatic log_mismatch(input int id, input logic [127:0] exp_val,
                              input logic [127:0] act_val);
    errors[id]++;
    $display("[ERROR] %s expected %h actual %h at %0t", test_name[id], exp_val, act_val,
             $time);
  endtask

  // new request only when none is waiting, payload held until handshake
  task automatic drive_inputs(input bit allow_new);
    if (!pending && allow_new && ($urandom % 5 < 3))
    begin
      pending = 1'b1;
      req_wait = 0;
      // about a third ctc
      if ($urandom % 3 == 0)
        ac.snoop = `SNP_CTC_CODE;
      else
        ac.snoop = 4'($urandom % 15);
      ac.addr = {8'($urandom), $urandom};
      ac.prot = 3'($urandom);
    end
    ac_req = pending;
    permit.lm_stall = ($urandom % 4 == 0);
    permit.create_permit = ($urandom % 4 != 0);
    // full order list blocks both queues
    permit.snq_entry_empty = ($urandom % 4 != 0) && (order_q.size() < `SNP_COQ_ENTRIES);
    permit.ctcq_entry_empty = ($urandom % 4 != 0) && (order_q.size() < `SNP_COQ_ENTRIES);
    wmb_depd = 8'($urandom);
    vb_depd = 2'($urandom);
    if ($urandom % 2 == 0)
      busy = '0;
    else
      busy = snp_busy_t'(3'($urandom));
    cr = '0;
    // response only for an outstanding entry, valid follows the head
    if (order_q.size() > 0 && $urandom % 2 == 0)
    begin
      cr.resp_accept = 1'b1;
      cr.snq_cr_valid = !order_q[0];
      cr.ctcq_cr_valid = order_q[0];
      cr.ctcq_2_cmplt = order_q[0] && ($urandom % 2 == 0);
    end
  endtask

  task automatic check_outputs();
    bit exp_ctc;
    bit exp_ready;
    logic [2:0] exp_hs;
    snq_entry_t exp_snq;
    ctcq_entry_t exp_ctcq;
    bit exp_empty;
    exp_ctc = (ac.snoop == `SNP_CTC_CODE);
    exp_ready = ac_req && !permit.lm_stall && permit.create_permit
             && (exp_ctc ? permit.ctcq_entry_empty : permit.snq_entry_empty);
    exp_hs = {exp_ready, exp_ready && !exp_ctc, exp_ready && exp_ctc};
    hs_now = exp_ready;
    hs_ctc = exp_ctc;
    checks[1]++;
    if ({ac_ready, snoop_create_en, ctc_create_en} !== exp_hs)
      log_mismatch(1, 128'(exp_hs), 128'({ac_ready, snoop_create_en, ctc_create_en}));
    if (ac_req)
    begin
      exp_snq.depd = {wmb_depd, vb_depd};
      exp_snq.snoop_type = ac.snoop;
      exp_snq.addr = ac.addr;
      exp_snq.prot = ac.prot;
      checks[2]++;
      if (snq_entry !== exp_snq)
        log_mismatch(2, 128'(exp_snq), 128'(snq_entry));
      // bit ranges of the first ctc transaction
      exp_ctcq.ctc_type = {ac.addr[14:12], ac.addr[6:5], ac.addr[0]};
      exp_ctcq.asid_va = ac.addr[39:16];
      exp_ctcq.second_trans = ac.addr[0];
      exp_ctcq.va_pa = ac.addr[39:4];
      checks[3]++;
      if (ctcq_entry !== exp_ctcq)
        log_mismatch(3, 128'(exp_ctcq), 128'(ctcq_entry));
    end
    // head of the order list picks the visible ring
    if (order_q.size() > 0)
    begin
      checks[4]++;
      checks[5]++;
      if (order_q[0])
      begin
        if (snq_oldest_index !== '0)
          log_mismatch(4, 128'(0), 128'(snq_oldest_index));
        if (ctcq_oldest_index !== ctcq_ring_m)
          log_mismatch(5, 128'(ctcq_ring_m), 128'(ctcq_oldest_index));
      end
      else
      begin
        if (ctcq_oldest_index !== '0)
          log_mismatch(4, 128'(0), 128'(ctcq_oldest_index));
        if (snq_oldest_index !== snq_ring_m)
          log_mismatch(5, 128'(snq_ring_m), 128'(snq_oldest_index));
      end
    end
    exp_empty = !ac_req && (busy == '0);
    checks[6]++;
    if (ac_empty !== exp_empty)
      log_mismatch(6, 128'(exp_empty), 128'(ac_empty));
  endtask

  // state change expected at the coming rising edge
  task automatic update_model();
    if (cr.resp_accept)
    begin
      if (cr.snq_cr_valid)
        snq_ring_m = {snq_ring_m[`SNP_SNQ_ENTRIES-2:0], snq_ring_m[`SNP_SNQ_ENTRIES-1]};
      // second transaction pending keeps the ctcq ring in place
      if (cr.ctcq_cr_valid && !cr.ctcq_2_cmplt)
        ctcq_ring_m = {ctcq_ring_m[`SNP_CTCQ_ENTRIES-2:0], ctcq_ring_m[`SNP_CTCQ_ENTRIES-1]};
      void'(order_q.pop_front());
    end
    if (hs_now)
    begin
      order_q.push_back(hs_ctc);
      pending = 1'b0;
    end
    else if (pending)
    begin
      req_wait++;
      if (req_wait > WAIT_LIMIT)
      begin
        $display("ac request not accepted within %0d cycles", WAIT_LIMIT);
        timed_out = 1'b1;
      end
    end
  endtask

  initial
  begin
    int seed_ret;
    int guard;
    int cycle;
    int total_checks;
    int total_errors;
    int assert_fails;
    seed_ret = $urandom(32'h1764_4806);
    ac_req = 1'b0;
    ac = '0;
    permit = '0;
    wmb_depd = '0;
    vb_depd = '0;
    busy = '0;
    cr = '0;
    snq_ring_m = `SNP_SNQ_ENTRIES'(1);
    ctcq_ring_m = `SNP_CTCQ_ENTRIES'(1);
    pending = 1'b0;
    req_wait = 0;
    timed_out = 1'b0;

    // ============================================================
    // reset
    // ============================================================

    // reset counts as active until it reads a clean 1
    guard = 0;
    while (cpurst_b !== 1'b1 && guard < RESET_LIMIT)
    begin
      @(negedge snpcrtclk);
      guard++;
    end
    if (cpurst_b !== 1'b1)
    begin
      $display("reset was not released within %0d cycles", RESET_LIMIT);
      timed_out = 1'b1;
    end
    #SETTLE_NS;
    checks[0]++;
    if ({snq_oldest_index, ctcq_oldest_index} !== {6'b000001, 6'b000000})
      log_mismatch(0, 128'({6'b000001, 6'b000000}),
                   128'({snq_oldest_index, ctcq_oldest_index}));
    $display("test %s: %0d checks, %0d errors", test_name[0], checks[0], errors[0]);

    // ============================================================
    // random phase then drain
    // ============================================================

    cycle = 0;
    while (!timed_out && (cycle < RAND_CYCLES || pending || order_q.size() > 0))
    begin
      @(negedge snpcrtclk);
      drive_inputs(cycle < RAND_CYCLES);
      #SETTLE_NS;
      check_outputs();
      update_model();
      cycle++;
      if (cycle >= RAND_CYCLES + DRAIN_LIMIT)
      begin
        $display("order list not drained after %0d cycles", DRAIN_LIMIT);
        timed_out = 1'b1;
      end
    end

    // ============================================================
    // report
    // ============================================================

    total_checks = checks[0];
    total_errors = errors[0];
    for (int i = 1; i < NUM_TESTS; i++)
    begin
      $display("test %s: %0d checks, %0d errors", test_name[i], checks[i], errors[i]);
      total_checks += checks[i];
      total_errors += errors[i];
    end
    assert_fails = snoop_req_arbiter_inst.assert_inst.assert_fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             total_checks, total_errors, assert_fails, int'(timed_out));
    if (total_errors == 0 && assert_fails == 0 && !timed_out)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/snoop_arb_pkg.sv
hw/snoop_admit.sv
hw/snoop_order_tracker.sv
hw/oldest_index_ring.sv
hw/snoop_req_arbiter.sv
verif/tb_clk_gen.sv
verif/snoop_req_arbiter_assert.sv
verif/snoop_req_arbiter_tb.sv

// ==== Makefile ====
# Verilator build and run of the snoop request arbiter testbench

TOP := snoop_req_arbiter_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
